// ==== all.f ====
hw/trace_pkg.sv
hw/trace_tag_store.sv
hw/trace_use_ages.sv
hw/trace_fill.sv
hw/trace_data_array.sv
hw/trace_cache.sv
test/trace_cache_assertions.sv
test/trace_cache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the trace cache testbench with Verilator and runs it.
# The exit status is the simulator's own.

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module trace_cache_tb \
	-Mdir obj_dir -o trace_cache_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build returned status $status"
	exit $status
fi

./obj_dir/trace_cache_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation returned status $status"
fi
exit $status

// ==== test/trace_cache_tb.sv ====
/*
 * Testbench of the trace cache.
 * Operations come from a table that is built at time zero. Expected values
 * are worked out from the cache rules as each entry is added.
 * Inputs change 1 ns after the rising edge, and outputs are read there too.
 * The run stops at the first mismatch.
 */
`default_nettype none

module trace_cache_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import trace_pkg::*;

	localparam int HIT_TIMEOUT = 20;
	localparam int GROUPS = 16;

	typedef enum logic [1:0] {
		OP_FILL,
		OP_LOOKUP,
		OP_INVALIDATE,
		OP_IDLE
	} op_kind_t;

	typedef struct packed {
		op_kind_t           kind;
		int                 cycles;
		pc_t [SLOTS-1:0]    pc;
		instr_t [SLOTS-1:0] instr;
		slot_mask_t         mask;
		logic               taken;
		pc_t                target;
		logic               exp_hit;
		slot_mask_t         exp_mask;
		pc_t                exp_next;
		pc_t [SLOTS-1:0]    exp_pc;
		instr_t [SLOTS-1:0] exp_instr;
	} op_t;

	logic               clk = 1'b0;
	logic               reset;
	logic               lookup_valid;
	pc_t                lookup_pc;
	logic               fill_valid;
	slot_mask_t         fill_slot_valid;
	pc_t [SLOTS-1:0]    fill_pc;
	instr_t [SLOTS-1:0] fill_instr;
	logic               fill_taken;
	pc_t                fill_target;
	logic               invalidate;
	logic               hit_valid;
	logic               hit;
	slot_mask_t         hit_slot_valid;
	pc_t [SLOTS-1:0]    hit_pc;
	instr_t [SLOTS-1:0] hit_instr;
	pc_t                hit_pc_next;

	op_t    ops[$];
	string  op_names[$];
	integer seed;

	// reference copy of every group handed to the cache, indexed by group id
	pc_t [SLOTS-1:0]    grp_pc [GROUPS];
	instr_t [SLOTS-1:0] grp_instr [GROUPS];
	slot_mask_t         grp_mask [GROUPS];
	pc_t                grp_next [GROUPS];

	always #5 clk = ~clk;

	trace_cache DUT (.*);

	task automatic check(input string name, input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			$display("Mismatch %s %s: expected %h, actual %h", name, what, expected, actual);
			$display("Simulation failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	function automatic slot_mask_t mask_of(input int n);
		slot_mask_t m;
		m = '0;
		for (int s = 0; s < n; s++) begin
			m[s] = 1'b1;
		end
		return m;
	endfunction

	// n sequential slots from base, remembered under id
	task automatic add_fill(input string name, input int id, input pc_t base, input int n,
		input logic taken, input pc_t target);
		op_t op;
		op = '0;
		op.kind = OP_FILL;
		for (int s = 0; s < SLOTS; s++) begin
			op.pc[s] = base + pc_t'(4 * s);
			op.instr[s] = $random(seed);
		end
		op.mask = mask_of(n);
		op.taken = taken;
		op.target = target;
		grp_pc[id] = op.pc;
		grp_instr[id] = op.instr;
		grp_mask[id] = op.mask;
		// branch target if taken, else the word after the last valid slot
		grp_next[id] = taken ? target : op.pc[n-1] + pc_t'(4);
		ops.push_back(op);
		op_names.push_back(name);
	endtask

	task automatic add_lookup(input string name, input pc_t pc, input logic exp_hit,
		input int id);
		op_t op;
		op = '0;
		op.kind = OP_LOOKUP;
		op.pc[0] = pc;
		op.exp_hit = exp_hit;
		if (exp_hit) begin
			op.exp_mask = grp_mask[id];
			op.exp_next = grp_next[id];
			op.exp_pc = grp_pc[id];
			op.exp_instr = grp_instr[id];
		end
		ops.push_back(op);
		op_names.push_back(name);
	endtask

	task automatic add_ctrl(input string name, input op_kind_t kind, input int cycles);
		op_t op;
		op = '0;
		op.kind = kind;
		op.cycles = cycles;
		ops.push_back(op);
		op_names.push_back(name);
	endtask

	task automatic build_table();
		add_lookup("reset_miss", 16'h1000, 1'b0, 0);
		add_lookup("reset_miss_zero", 16'h0000, 1'b0, 0);
		add_fill("fill_full", 0, 16'h1000, 4, 1'b0, 16'h0000);
		add_lookup("hit_full", 16'h1000, 1'b1, 0);
		add_fill("fill_two", 1, 16'h2000, 2, 1'b0, 16'h0000);
		add_lookup("hit_two", 16'h2000, 1'b1, 1);
		// only the start pc of a group is a tag
		add_lookup("miss_mid_group", 16'h1004, 1'b0, 0);
		add_fill("fill_taken", 2, 16'h3000, 3, 1'b1, 16'h4440);
		add_lookup("hit_taken", 16'h3000, 1'b1, 2);
		// same start pc with new words must not replace the line
		add_fill("fill_dup", 3, 16'h1000, 4, 1'b0, 16'h0000);
		add_lookup("dup_keeps_first", 16'h1000, 1'b1, 0);
		add_ctrl("invalidate_all", OP_INVALIDATE, 1);
		add_lookup("inval_miss_full", 16'h1000, 1'b0, 0);
		add_lookup("inval_miss_two", 16'h2000, 1'b0, 0);
		add_lookup("inval_miss_taken", 16'h3000, 1'b0, 0);
		// every line in use, so the ninth group has nowhere to go
		for (int g = 0; g < LINES; g++) begin
			add_fill($sformatf("fill_line%0d", g), 4 + g, 16'h5000 + pc_t'(g * 'h100), 4,
				1'b0, 16'h0000);
		end
		add_fill("fill_ninth", 12, 16'h6000, 4, 1'b0, 16'h0000);
		add_lookup("ninth_miss", 16'h6000, 1'b0, 12);
		add_ctrl("age_out", OP_IDLE, 9 * AGE_PERIOD);
		add_fill("fill_after_aging", 13, 16'h7000, 2, 1'b1, 16'h0100);
		add_lookup("line0_replaced", 16'h5000, 1'b0, 4);
		add_lookup("hit_after_aging", 16'h7000, 1'b1, 13);
		add_lookup("line1_kept", 16'h5100, 1'b1, 5);
		add_ctrl("invalidate_end", OP_INVALIDATE, 1);
		add_lookup("final_miss", 16'h7000, 1'b0, 13);
	endtask

	task automatic apply(input op_t op, input string name);
		int waited;
		case (op.kind)
			OP_FILL: begin
				fill_valid = 1'b1;
				fill_slot_valid = op.mask;
				fill_pc = op.pc;
				fill_instr = op.instr;
				fill_taken = op.taken;
				fill_target = op.target;
				@(posedge clk);
				#1;
				fill_valid = 1'b0;
			end
			OP_LOOKUP: begin
				lookup_valid = 1'b1;
				lookup_pc = op.pc[0];
				@(posedge clk);
				#1;
				lookup_valid = 1'b0;
				waited = 0;
				while (!hit_valid) begin
					if (waited == HIT_TIMEOUT) begin
						$display("hit_valid never arrived for %s", name);
						$display("Simulation failed");
						$fatal(1, "lookup timed out");
					end
					@(posedge clk);
					#1;
					waited++;
				end
				check(name, "hit", 64'(op.exp_hit), 64'(hit));
				if (op.exp_hit) begin
					check(name, "slot mask", 64'(op.exp_mask), 64'(hit_slot_valid));
					check(name, "next pc", 64'(op.exp_next), 64'(hit_pc_next));
					// slots past the mask carry no meaning
					for (int s = 0; s < SLOTS; s++) begin
						if (op.exp_mask[s]) begin
							check(name, $sformatf("slot %0d pc", s), 64'(op.exp_pc[s]),
								64'(hit_pc[s]));
							check(name, $sformatf("slot %0d instr", s), 64'(op.exp_instr[s]),
								64'(hit_instr[s]));
						end
					end
				end
			end
			OP_INVALIDATE: begin
				invalidate = 1'b1;
				@(posedge clk);
				#1;
				invalidate = 1'b0;
			end
			default: begin
				for (int c = 0; c < op.cycles; c++) begin
					@(posedge clk);
				end
				#1;
			end
		endcase
	endtask

	initial begin
		seed = 32'hff2d69e0;
		reset = 1'b1;
		lookup_valid = 1'b0;
		lookup_pc = '0;
		fill_valid = 1'b0;
		fill_slot_valid = '0;
		fill_pc = '0;
		fill_instr = '0;
		fill_taken = 1'b0;
		fill_target = '0;
		invalidate = 1'b0;
		build_table();
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		for (int i = 0; i < ops.size(); i++) begin
			apply(ops[i], op_names[i]);
		end
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/trace_cache_assertions.sv ====
/*
 * Port protocol checks of the trace cache, bound to every trace_cache.
 * Nothing is checked while reset is high.
 */
`default_nettype none

module trace_cache_assertions (
	input logic                  clk,
	input logic                  reset,
	input logic                  lookup_valid,
	input logic                  fill_valid,
	input trace_pkg::slot_mask_t fill_slot_valid,
	input logic                  hit_valid,
	input logic                  hit
);
	timeunit 1ns;
	timeprecision 1ps;

	import trace_pkg::*;

	slot_mask_t mask_step;

	// a mask contiguous from bit 0, plus one, shares no bit with itself
	assign mask_step = fill_slot_valid + slot_mask_t'(1);

	lookup_answered: assert property (@(posedge clk) disable iff (reset)
		lookup_valid |=> hit_valid)
		else $error("lookup strobe got no hit_valid in the next cycle");

	no_stray_answer: assert property (@(posedge clk) disable iff (reset)
		!lookup_valid |=> !hit_valid)
		else $error("hit_valid without a lookup in the previous cycle");

	hit_qualified: assert property (@(posedge clk) disable iff (reset)
		hit |-> hit_valid)
		else $error("hit is high while hit_valid is low");

	fill_mask_contiguous: assert property (@(posedge clk) disable iff (reset)
		fill_valid |-> ((mask_step & fill_slot_valid) == '0))
		else $error("fill_slot_valid is not contiguous from slot 0");

endmodule

bind trace_cache trace_cache_assertions u_assertions (
	.clk             (clk),
	.reset           (reset),
	.lookup_valid    (lookup_valid),
	.fill_valid      (fill_valid),
	.fill_slot_valid (fill_slot_valid),
	.hit_valid       (hit_valid),
	.hit             (hit)
);

`default_nettype wire

// ==== hw/trace_cache.sv ====
/*
 * Trace cache top level.
 * All inputs are single-cycle strobes and are always accepted.
 * A lookup in cycle t answers in cycle t+1 with hit_valid high for one cycle.
 * A fill in cycle t is visible to lookups from t+1 on; fills that repeat a
 * stored start pc, or find no free line, are dropped without notice.
 * invalidate empties the whole cache at the end of its cycle.
 */
`default_nettype none

module trace_cache (
	input  logic                                    clk,
	input  logic                                    reset,
	input  logic                                    lookup_valid,
	input  trace_pkg::pc_t                          lookup_pc,
	input  logic                                    fill_valid,
	input  trace_pkg::slot_mask_t                   fill_slot_valid,
	input  trace_pkg::pc_t [trace_pkg::SLOTS-1:0]    fill_pc,
	input  trace_pkg::instr_t [trace_pkg::SLOTS-1:0] fill_instr,
	input  logic                                    fill_taken,
	input  trace_pkg::pc_t                          fill_target,
	input  logic                                    invalidate,
	output logic                                    hit_valid,
	output logic                                    hit,
	output trace_pkg::slot_mask_t                   hit_slot_valid,
	output trace_pkg::pc_t [trace_pkg::SLOTS-1:0]    hit_pc,
	output trace_pkg::instr_t [trace_pkg::SLOTS-1:0] hit_instr,
	output trace_pkg::pc_t                          hit_pc_next
);
	import trace_pkg::*;

	line_mask_t lookup_match;
	logic       fill_match;
	logic       victim_ok;
	line_idx_t  victim;
	logic       write_en;
	line_idx_t  write_line;
	pc_t        write_next_pc;

	trace_tag_store u_tag_store (
		.clk              (clk),
		.reset            (reset),
		.invalidate       (invalidate),
		.lookup_valid     (lookup_valid),
		.lookup_pc        (lookup_pc),
		.fill_pc0         (fill_pc[0]),
		.write_en         (write_en),
		.write_line       (write_line),
		.write_slot_valid (fill_slot_valid),
		.write_next_pc    (write_next_pc),
		.lookup_match     (lookup_match),
		.fill_match       (fill_match),
		.hit_valid        (hit_valid),
		.hit              (hit),
		.hit_slot_valid   (hit_slot_valid),
		.hit_pc_next      (hit_pc_next)
	);

	trace_use_ages u_use_ages (
		.clk          (clk),
		.reset        (reset),
		.invalidate   (invalidate),
		.lookup_valid (lookup_valid),
		.lookup_match (lookup_match),
		.write_en     (write_en),
		.write_line   (write_line),
		.victim_ok    (victim_ok),
		.victim       (victim)
	);

	// combines the tag match and the victim search
	trace_fill u_fill (
		.fill_valid      (fill_valid),
		.fill_slot_valid (fill_slot_valid),
		.fill_pc         (fill_pc),
		.fill_taken      (fill_taken),
		.fill_target     (fill_target),
		.fill_match      (fill_match),
		.victim_ok       (victim_ok),
		.victim          (victim),
		.write_en        (write_en),
		.write_line      (write_line),
		.write_next_pc   (write_next_pc)
	);

	trace_data_array u_data_array (
		.clk          (clk),
		.write_en     (write_en),
		.write_line   (write_line),
		.fill_pc      (fill_pc),
		.fill_instr   (fill_instr),
		.lookup_match (lookup_match),
		.hit_pc       (hit_pc),
		.hit_instr    (hit_instr)
	);

endmodule

`default_nettype wire

// ==== hw/trace_data_array.sv ====
/*
 * Slot storage of the trace cache, one pc and instruction per slot.
 * Writes take effect at the clock edge; the read is a one-hot mux on
 * lookup_match into an output register, so data follows one cycle later.
 * On a miss the outputs read as zero.
 */
`default_nettype none

module trace_data_array (
	input  logic                                    clk,
	input  logic                                    write_en,
	input  trace_pkg::line_idx_t                    write_line,
	input  trace_pkg::pc_t [trace_pkg::SLOTS-1:0]    fill_pc,
	input  trace_pkg::instr_t [trace_pkg::SLOTS-1:0] fill_instr,
	input  trace_pkg::line_mask_t                   lookup_match,
	output trace_pkg::pc_t [trace_pkg::SLOTS-1:0]    hit_pc,
	output trace_pkg::instr_t [trace_pkg::SLOTS-1:0] hit_instr
);
	import trace_pkg::*;

	pc_t [SLOTS-1:0]    line_pc [LINES];
	instr_t [SLOTS-1:0] line_instr [LINES];

	pc_t [SLOTS-1:0]    sel_pc;
	instr_t [SLOTS-1:0] sel_instr;

	// whole group written at once, invalid slots are masked by the tag store
	always_ff @(posedge clk) begin
		if (write_en) begin
			line_pc[write_line] <= fill_pc;
			line_instr[write_line] <= fill_instr;
		end
	end

	// at most one line matches, so an or of the gated lines is enough
	always_comb begin
		sel_pc = '0;
		sel_instr = '0;
		for (int i = 0; i < LINES; i++) begin
			if (lookup_match[i]) begin
				sel_pc = sel_pc | line_pc[i];
				sel_instr = sel_instr | line_instr[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		hit_pc <= sel_pc;
		hit_instr <= sel_instr;
	end

endmodule

`default_nettype wire

// ==== hw/trace_fill.sv ====
/*
 * Fill decision of the trace cache, purely combinational.
 * fill_slot_valid must be contiguous from slot 0, and fill_taken and
 * fill_target describe the last valid slot.
 * A group is written only when slot 0 is valid, no valid line already
 * starts at the same pc and a free line exists. Otherwise it is dropped.
 */
`default_nettype none

module trace_fill (
	input  logic                                 fill_valid,
	input  trace_pkg::slot_mask_t                fill_slot_valid,
	input  trace_pkg::pc_t [trace_pkg::SLOTS-1:0] fill_pc,
	input  logic                                 fill_taken,
	input  trace_pkg::pc_t                       fill_target,
	input  logic                                 fill_match,
	input  logic                                 victim_ok,
	input  trace_pkg::line_idx_t                 victim,
	output logic                                 write_en,
	output trace_pkg::line_idx_t                 write_line,
	output trace_pkg::pc_t                       write_next_pc
);
	import trace_pkg::*;

	pc_t  last_pc;
	pc_t  fall_through;
	logic group_ok;

	// pc of the highest valid slot, which is the last one for a contiguous mask
	always_comb begin
		last_pc = fill_pc[0];
		for (int s = 1; s < SLOTS; s++) begin
			if (fill_slot_valid[s]) begin
				last_pc = fill_pc[s];
			end
		end
	end

	assign fall_through = last_pc + pc_t'(INSN_BYTES);

	// taken branch at the end of the group redirects the next fetch
	assign write_next_pc = fill_taken ? fill_target : fall_through;

	// a group must start at slot 0 to be usable as a trace
	assign group_ok = fill_valid && fill_slot_valid[0];

	assign write_en = group_ok && !fill_match && victim_ok;
	assign write_line = victim;

endmodule

`default_nettype wire

// ==== hw/trace_use_ages.sv ====
/*
 * Use counts of the trace cache lines and choice of a replacement victim.
 * The aging counter runs freely from reset and ticks every AGE_PERIOD cycles.
 * Victim is the lowest-index line whose count is zero; victim_ok is low
 * when every line is in use, and then fills are dropped.
 * AGE_PERIOD must be a power of two no smaller than 2.
 */
`default_nettype none

module trace_use_ages (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  invalidate,
	input  logic                  lookup_valid,
	input  trace_pkg::line_mask_t lookup_match,
	input  logic                  write_en,
	input  trace_pkg::line_idx_t  write_line,
	output logic                  victim_ok,
	output trace_pkg::line_idx_t  victim
);
	import trace_pkg::*;

	typedef logic [$clog2(AGE_PERIOD)-1:0] age_t;

	age_t age_count;
	logic age_tick;
	use_t use_count [LINES];

	// free running aging period counter
	always_ff @(posedge clk) begin
		if (reset) begin
			age_count <= '0;
		end else if (age_tick) begin
			age_count <= '0;
		end else begin
			age_count <= age_count + 1'b1;
		end
	end

	assign age_tick = (age_count == age_t'(AGE_PERIOD - 1));

	// per-line counts, highest priority first
	always_ff @(posedge clk) begin
		for (int i = 0; i < LINES; i++) begin
			if (reset || invalidate) begin
				use_count[i] <= '0;
			end else if (write_en && (write_line == line_idx_t'(i))) begin
				// a fresh line starts with some credit
				if (use_count[i] < use_t'(FILL_USE)) begin
					use_count[i] <= use_t'(FILL_USE);
				end
			end else if (lookup_valid && lookup_match[i] && !age_tick) begin
				if (use_count[i] < use_t'(USE_MAX)) begin
					use_count[i] <= use_count[i] + 1'b1;
				end
			end else if (age_tick && (use_count[i] != '0)) begin
				use_count[i] <= use_count[i] - 1'b1;
			end
		end
	end

	// lowest free line, scanned from the top so index 0 wins
	always_comb begin
		victim_ok = 1'b0;
		victim = '0;
		for (int i = LINES - 1; i >= 0; i--) begin
			if (use_count[i] == '0) begin
				victim_ok = 1'b1;
				victim = line_idx_t'(i);
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/trace_tag_store.sv ====
/*
 * Per-line metadata of the trace cache: valid bit, tag, slot mask, next pc.
 * Matching is combinational against registered state, so a fill written
 * in cycle t is only visible to lookups from cycle t+1.
 * Lookup results appear one cycle after the strobe.
 * Invalidate clears every valid bit at the end of the cycle.
 */
`default_nettype none

module trace_tag_store (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  invalidate,
	input  logic                  lookup_valid,
	input  trace_pkg::pc_t        lookup_pc,
	input  trace_pkg::pc_t        fill_pc0,
	input  logic                  write_en,
	input  trace_pkg::line_idx_t  write_line,
	input  trace_pkg::slot_mask_t write_slot_valid,
	input  trace_pkg::pc_t        write_next_pc,
	output trace_pkg::line_mask_t lookup_match,
	output logic                  fill_match,
	output logic                  hit_valid,
	output logic                  hit,
	output trace_pkg::slot_mask_t hit_slot_valid,
	output trace_pkg::pc_t        hit_pc_next
);
	import trace_pkg::*;

	line_mask_t line_valid;
	pc_t        line_tag [LINES];
	slot_mask_t line_slots [LINES];
	pc_t        line_next [LINES];

	line_mask_t fill_hits;
	slot_mask_t sel_slots;
	pc_t        sel_next;

	// associative compare of both the lookup pc and the fill start pc
	always_comb begin
		for (int i = 0; i < LINES; i++) begin
			lookup_match[i] = line_valid[i] && (line_tag[i] == lookup_pc);
			fill_hits[i] = line_valid[i] && (line_tag[i] == fill_pc0);
		end
	end

	assign fill_match = |fill_hits;

	// one-hot select of the matching line's metadata, zero on a miss
	always_comb begin
		sel_slots = '0;
		sel_next = '0;
		for (int i = 0; i < LINES; i++) begin
			if (lookup_match[i]) begin
				sel_slots = sel_slots | line_slots[i];
				sel_next = sel_next | line_next[i];
			end
		end
	end

	// valid bits, invalidate wins over a fill in the same cycle
	always_ff @(posedge clk) begin
		if (reset || invalidate) begin
			line_valid <= '0;
		end else if (write_en) begin
			line_valid[write_line] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (write_en) begin
			line_tag[write_line] <= fill_pc0;
			line_slots[write_line] <= write_slot_valid;
			line_next[write_line] <= write_next_pc;
		end
	end

	// registered lookup outcome
	always_ff @(posedge clk) begin
		if (reset) begin
			hit_valid <= 1'b0;
			hit <= 1'b0;
		end else begin
			hit_valid <= lookup_valid;
			hit <= lookup_valid && (|lookup_match);
		end
	end

	always_ff @(posedge clk) begin
		hit_slot_valid <= sel_slots;
		hit_pc_next <= sel_next;
	end

endmodule

`default_nettype wire

// ==== hw/trace_pkg.sv ====
/*
 * Shared sizes and types of the trace cache.
 * Every instruction is 4 bytes, so compressed code is not supported.
 * LINES and SLOTS are expected to be powers of two.
 * AGE_PERIOD sets how many cycles pass between aging ticks.
 */
`default_nettype none

package trace_pkg;

	// geometry
	localparam int SLOTS = 4;
	localparam int LINES = 8;

	// address and instruction widths
	localparam int PC_W = 16;
	localparam int INSTR_W = 32;

	// every slot advances the pc by one full word
	localparam int INSN_BYTES = 4;

	// use count behaviour
	localparam int USE_W = 3;
	localparam int USE_MAX = 7;
	localparam int FILL_USE = 2;

	// cycles between aging ticks
	localparam int AGE_PERIOD = 64;

	typedef logic [PC_W-1:0] pc_t;
	typedef logic [INSTR_W-1:0] instr_t;
	typedef logic [SLOTS-1:0] slot_mask_t;
	typedef logic [LINES-1:0] line_mask_t;
	typedef logic [$clog2(LINES)-1:0] line_idx_t;
	typedef logic [USE_W-1:0] use_t;

endpackage

`default_nettype wire
